/* design/qracc_cfg.svh */
// ##########################################################
// QR accelerator configuration
// Array, ADC and SRAM address sizes for the wrapper
// ##########################################################
`ifndef QRACC_CFG_SVH
`define QRACC_CFG_SVH

// Array geometry
`define QRACC_ROWS 16
`define QRACC_COLS 4

// ADC resolution, one comparator per code step
`define QRACC_ADC_BITS 4
`define QRACC_COMPS 15

// Word address, one wordline per row
`define QRACC_ADDR_W 4

`endif

/* design/qracc_pkg.sv */
// ##########################################################
// QR accelerator types
// Vector typedefs and the SRAM sequencer state encoding
// ##########################################################
`include "qracc_cfg.svh"

package qracc_pkg;

    // One bit per array row (data, selects, wordlines)
    typedef logic [`QRACC_ROWS-1:0] row_vec_t;

    // One array word, a bit per column
    typedef logic [`QRACC_COLS-1:0] col_word_t;

    // Comparator outputs of one column ADC
    typedef logic [`QRACC_COMPS-1:0] therm_t;

    // Signed column result, -8 .. 7
    typedef logic signed [`QRACC_ADC_BITS-1:0] adc_code_t;

    typedef logic [`QRACC_ADDR_W-1:0] addr_t;

    // Word access sequencer
    typedef enum logic [2:0] {
        IDLE,      // Ready for a request
        PRECH,     // Bitline precharge
        WORDLINE,  // Wordline on, write drive for writes
        SENSE,     // Sense amp enable, reads only
        DONE
    } sram_state_e;

endpackage

/* design/qracc_mac_if.sv */
// ##########################################################
// MAC request bundle
// Captured request from the input stage to the drivers
// ##########################################################
`timescale 1ns/1ps

interface qracc_mac_if;

    logic                 mac_en;      // Captured MAC enable
    qracc_pkg::row_vec_t  data_p;      // Positive data bits
    qracc_pkg::row_vec_t  data_n;      // Negative data bits
    logic                 binary_cfg;  // Binary mode, NSM parked

    modport src (
        output mac_en, data_p, data_n, binary_cfg
    );

    modport dst (
        input mac_en, data_p, data_n, binary_cfg
    );

endinterface

/* design/qracc_input_stage.sv */
// ##########################################################
// MAC input stage
// Registers the request so the analog drive is clock aligned
// ##########################################################
`timescale 1ns/1ps

module qracc_input_stage (
    input  logic                clk,
    input  logic                nrst,

    // Raw request from the top level
    input  logic                mac_en_i,
    input  qracc_pkg::row_vec_t data_p_i,
    input  qracc_pkg::row_vec_t data_n_i,
    input  logic                binary_cfg_i,

    // Captured request
    qracc_mac_if.src            mac
);

    logic                mac_en_q;
    qracc_pkg::row_vec_t data_p_q;
    qracc_pkg::row_vec_t data_n_q;
    logic                binary_cfg_q;

    // New request taken every edge, no stall
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mac_en_q     <= 1'b0;
            data_p_q     <= '0;
            data_n_q     <= '0;
            binary_cfg_q <= 1'b0;
        end else begin
            mac_en_q     <= mac_en_i;
            data_p_q     <= data_p_i;
            data_n_q     <= data_n_i;
            binary_cfg_q <= binary_cfg_i;
        end
    end

    assign mac.mac_en     = mac_en_q;
    assign mac.data_p     = data_p_q;
    assign mac.data_n     = data_n_q;
    assign mac.binary_cfg = binary_cfg_q;

endmodule

/* design/qracc_switch_driver.sv */
// ##########################################################
// Switch matrix driver
// Row selects and ADC feedback controls per clock phase
// ##########################################################
`timescale 1ns/1ps

module qracc_switch_driver (
    input  logic                clk,
    qracc_mac_if.dst            mac,

    // Positive switch matrix
    output qracc_pkg::row_vec_t psm_vdr_sel_o,
    output qracc_pkg::row_vec_t psm_vdr_selb_o,
    output qracc_pkg::row_vec_t psm_vss_sel_o,
    output qracc_pkg::row_vec_t psm_vss_selb_o,
    output qracc_pkg::row_vec_t psm_vrst_sel_o,
    output qracc_pkg::row_vec_t psm_vrst_selb_o,

    // Negative switch matrix
    output qracc_pkg::row_vec_t nsm_vdr_sel_o,
    output qracc_pkg::row_vec_t nsm_vdr_selb_o,
    output qracc_pkg::row_vec_t nsm_vss_sel_o,
    output qracc_pkg::row_vec_t nsm_vss_selb_o,
    output qracc_pkg::row_vec_t nsm_vrst_sel_o,
    output qracc_pkg::row_vec_t nsm_vrst_selb_o,

    // ADC feedback and transfer switches
    output logic                nf_o,
    output logic                nfb_o,
    output logic                r2a_o,
    output logic                r2ab_o,
    output logic                m2a_o,
    output logic                m2ab_o
);

    qracc_pkg::row_vec_t dec_vdr;
    qracc_pkg::row_vec_t dec_vss;
    qracc_pkg::row_vec_t dec_vrst;
    logic                precharge;

    // Row decode: positive only to VDR, negative only to VSS, else reset
    assign dec_vdr  = mac.data_p & ~mac.data_n;
    assign dec_vss  = mac.data_n & ~mac.data_p;
    assign dec_vrst = ~(mac.data_p ^ mac.data_n);

    // High clock phase resets the array, only when a MAC is running
    assign precharge = clk && mac.mac_en;

    always_comb begin
        if (precharge) begin
            psm_vdr_sel_o  = '0;
            psm_vss_sel_o  = '0;
            psm_vrst_sel_o = '1;
            nsm_vdr_sel_o  = '0;
            nsm_vss_sel_o  = '0;
            nsm_vrst_sel_o = '1;
        end else begin
            psm_vdr_sel_o  = dec_vdr;
            psm_vss_sel_o  = dec_vss;
            psm_vrst_sel_o = dec_vrst;
            if (mac.binary_cfg) begin
                nsm_vdr_sel_o  = '0;  // NSM parked in binary mode
                nsm_vss_sel_o  = '0;
                nsm_vrst_sel_o = '1;
            end else begin
                nsm_vdr_sel_o  = dec_vss;  // Mirrored rails
                nsm_vss_sel_o  = dec_vdr;
                nsm_vrst_sel_o = dec_vrst;
            end
        end
    end

    assign psm_vdr_selb_o  = ~psm_vdr_sel_o;
    assign psm_vss_selb_o  = ~psm_vss_sel_o;
    assign psm_vrst_selb_o = ~psm_vrst_sel_o;
    assign nsm_vdr_selb_o  = ~nsm_vdr_sel_o;
    assign nsm_vss_selb_o  = ~nsm_vss_sel_o;
    assign nsm_vrst_selb_o = ~nsm_vrst_sel_o;

    // Negative feedback is power hungry, so only during precharge
    assign nf_o   = precharge;
    assign r2a_o  = precharge;
    assign m2a_o  = ~precharge;
    assign nfb_o  = ~nf_o;
    assign r2ab_o = ~r2a_o;
    assign m2ab_o = ~m2a_o;

endmodule

/* design/qracc_adc_encoder.sv */
// ##########################################################
// ADC encoder
// Thermometer codes to registered signed column results
// ##########################################################
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module qracc_adc_encoder (
    input  logic                                    clk,
    input  logic                                    nrst,
    qracc_mac_if.dst                                mac,

    input  qracc_pkg::therm_t   [`QRACC_COLS-1:0]   therm_i,
    output qracc_pkg::adc_code_t [`QRACC_COLS-1:0]  adc_out_o,
    output logic                                    adc_valid_o
);

    qracc_pkg::adc_code_t [`QRACC_COLS-1:0] adc_enc;

    // Highest set comparator (from 1) minus mid scale, all zero is -8
    function automatic qracc_pkg::adc_code_t therm_to_code(input qracc_pkg::therm_t therm);
        int top;
        top = 0;
        for (int i = 0; i < `QRACC_COMPS; i++) begin
            if (therm[i]) begin
                top = i + 1;
            end
        end
        return qracc_pkg::adc_code_t'(top - (1 << (`QRACC_ADC_BITS - 1)));
    endfunction

    always_comb begin
        for (int c = 0; c < `QRACC_COLS; c++) begin
            adc_enc[c] = therm_to_code(therm_i[c]);
        end
    end

    // Sampled at the end of the analog phase
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            adc_out_o   <= '0;
            adc_valid_o <= 1'b0;
        end else begin
            adc_out_o   <= adc_enc;
            adc_valid_o <= mac.mac_en;  // Request captured one edge earlier
        end
    end

endmodule

/* design/qracc_sram_ctrl.sv */
// ##########################################################
// SRAM access controller
// Precharge, wordline, write and sense phases for one word
// ##########################################################
`timescale 1ns/1ps

module qracc_sram_ctrl (
    input  logic                 clk,
    input  logic                 nrst,

    // Request side
    input  logic                 valid_i,
    input  logic                 wr_i,
    input  qracc_pkg::addr_t     addr_i,
    input  qracc_pkg::col_word_t wdata_i,
    output logic                 ready_o,
    output qracc_pkg::col_word_t rdata_o,
    output logic                 rvalid_o,

    // Array side
    input  qracc_pkg::col_word_t sa_out_i,
    output qracc_pkg::row_vec_t  wl_o,
    output logic                 w2b_o,
    output logic                 pch_o,    // Active low precharge
    output logic                 saen_o,
    output logic                 csel_o,
    output qracc_pkg::col_word_t wr_data_o
);

    qracc_pkg::sram_state_e state_q;
    qracc_pkg::sram_state_e state_d;
    logic                   accept;

    // Latched request
    logic                   wr_q;
    qracc_pkg::addr_t       addr_q;
    qracc_pkg::col_word_t   wdata_q;

    assign ready_o = (state_q == qracc_pkg::IDLE);
    assign accept  = valid_i && ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            qracc_pkg::IDLE:     if (accept) state_d = qracc_pkg::PRECH;
            qracc_pkg::PRECH:    state_d = qracc_pkg::WORDLINE;
            qracc_pkg::WORDLINE: state_d = wr_q ? qracc_pkg::DONE : qracc_pkg::SENSE;
            qracc_pkg::SENSE:    state_d = qracc_pkg::DONE;
            qracc_pkg::DONE:     state_d = qracc_pkg::IDLE;
            default:             state_d = qracc_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q  <= qracc_pkg::IDLE;
            rvalid_o <= 1'b0;
        end else begin
            state_q  <= state_d;
            rvalid_o <= (state_q == qracc_pkg::DONE) && !wr_q;
        end
    end

    // Request and read data payload
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_q    <= wr_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        if ((state_q == qracc_pkg::DONE) && !wr_q) begin
            rdata_o <= sa_out_i;
        end
    end

    // Array phase controls
    always_comb begin
        wl_o = '0;
        if ((state_q == qracc_pkg::WORDLINE) || (state_q == qracc_pkg::SENSE)) begin
            wl_o = qracc_pkg::row_vec_t'(1) << addr_q;  // One-hot row
        end
    end

    assign pch_o     = (state_q != qracc_pkg::PRECH);
    assign w2b_o     = (state_q == qracc_pkg::WORDLINE) && wr_q;
    assign saen_o    = (state_q == qracc_pkg::SENSE);
    assign csel_o    = (state_q != qracc_pkg::IDLE);
    assign wr_data_o = wdata_q;

endmodule

/* design/qracc_wrapper.sv */
// ##########################################################
// QR accelerator wrapper
// MAC pipeline and SRAM controller around the analog macro
// ##########################################################
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module qracc_wrapper (
    input  logic                                    clk,
    input  logic                                    nrst,

    // MAC request
    input  logic                                    mac_en_i,
    input  qracc_pkg::row_vec_t                     data_p_i,
    input  qracc_pkg::row_vec_t                     data_n_i,
    input  logic                                    binary_cfg_i,

    // Switch matrix drive
    output qracc_pkg::row_vec_t                     psm_vdr_sel_o,
    output qracc_pkg::row_vec_t                     psm_vdr_selb_o,
    output qracc_pkg::row_vec_t                     psm_vss_sel_o,
    output qracc_pkg::row_vec_t                     psm_vss_selb_o,
    output qracc_pkg::row_vec_t                     psm_vrst_sel_o,
    output qracc_pkg::row_vec_t                     psm_vrst_selb_o,
    output qracc_pkg::row_vec_t                     nsm_vdr_sel_o,
    output qracc_pkg::row_vec_t                     nsm_vdr_selb_o,
    output qracc_pkg::row_vec_t                     nsm_vss_sel_o,
    output qracc_pkg::row_vec_t                     nsm_vss_selb_o,
    output qracc_pkg::row_vec_t                     nsm_vrst_sel_o,
    output qracc_pkg::row_vec_t                     nsm_vrst_selb_o,
    output logic                                    nf_o,
    output logic                                    nfb_o,
    output logic                                    r2a_o,
    output logic                                    r2ab_o,
    output logic                                    m2a_o,
    output logic                                    m2ab_o,

    // ADC
    input  qracc_pkg::therm_t    [`QRACC_COLS-1:0]  therm_i,
    output qracc_pkg::adc_code_t [`QRACC_COLS-1:0]  adc_out_o,
    output logic                                    adc_valid_o,

    // SRAM request port
    input  logic                                    sram_valid_i,
    input  logic                                    sram_wr_i,
    input  qracc_pkg::addr_t                        sram_addr_i,
    input  qracc_pkg::col_word_t                    sram_wdata_i,
    output logic                                    sram_ready_o,
    output qracc_pkg::col_word_t                    sram_rdata_o,
    output logic                                    sram_rvalid_o,

    // Bitcell array controls
    input  qracc_pkg::col_word_t                    sa_out_i,
    output qracc_pkg::row_vec_t                     wl_o,
    output logic                                    w2b_o,
    output logic                                    pch_o,
    output logic                                    saen_o,
    output logic                                    csel_o,
    output qracc_pkg::col_word_t                    wr_data_o
);

    qracc_mac_if i_mac_if ();

    qracc_input_stage i_input_stage (
        .clk          (clk),
        .nrst         (nrst),
        .mac_en_i     (mac_en_i),
        .data_p_i     (data_p_i),
        .data_n_i     (data_n_i),
        .binary_cfg_i (binary_cfg_i),
        .mac          (i_mac_if.src)
    );

    qracc_switch_driver i_switch_driver (
        .clk             (clk),
        .mac             (i_mac_if.dst),
        .psm_vdr_sel_o   (psm_vdr_sel_o),
        .psm_vdr_selb_o  (psm_vdr_selb_o),
        .psm_vss_sel_o   (psm_vss_sel_o),
        .psm_vss_selb_o  (psm_vss_selb_o),
        .psm_vrst_sel_o  (psm_vrst_sel_o),
        .psm_vrst_selb_o (psm_vrst_selb_o),
        .nsm_vdr_sel_o   (nsm_vdr_sel_o),
        .nsm_vdr_selb_o  (nsm_vdr_selb_o),
        .nsm_vss_sel_o   (nsm_vss_sel_o),
        .nsm_vss_selb_o  (nsm_vss_selb_o),
        .nsm_vrst_sel_o  (nsm_vrst_sel_o),
        .nsm_vrst_selb_o (nsm_vrst_selb_o),
        .nf_o            (nf_o),
        .nfb_o           (nfb_o),
        .r2a_o           (r2a_o),
        .r2ab_o          (r2ab_o),
        .m2a_o           (m2a_o),
        .m2ab_o          (m2ab_o)
    );

    // Valid follows the captured enable by one more edge
    qracc_adc_encoder i_adc_encoder (
        .clk         (clk),
        .nrst        (nrst),
        .mac         (i_mac_if.dst),
        .therm_i     (therm_i),
        .adc_out_o   (adc_out_o),
        .adc_valid_o (adc_valid_o)
    );

    qracc_sram_ctrl i_sram_ctrl (
        .clk       (clk),
        .nrst      (nrst),
        .valid_i   (sram_valid_i),
        .wr_i      (sram_wr_i),
        .addr_i    (sram_addr_i),
        .wdata_i   (sram_wdata_i),
        .ready_o   (sram_ready_o),
        .rdata_o   (sram_rdata_o),
        .rvalid_o  (sram_rvalid_o),
        .sa_out_i  (sa_out_i),
        .wl_o      (wl_o),
        .w2b_o     (w2b_o),
        .pch_o     (pch_o),
        .saen_o    (saen_o),
        .csel_o    (csel_o),
        .wr_data_o (wr_data_o)
    );

endmodule

/* bench/qracc_tb.sv */
// ##########################################################
// QR accelerator wrapper testbench
// Table driven MAC and SRAM checks against an analog model
// ##########################################################
`timescale 1ns/1ps
`include "qracc_cfg.svh"

module qracc_tb;

    localparam int N_FIX = 8;
    localparam int N_VEC = 16;
    localparam int N_WR  = 6;
    localparam int N_OPS = 2 * N_WR + 2;

    typedef struct packed {
        logic                                 en;
        logic                                 bin;
        qracc_pkg::row_vec_t                  p;
        qracc_pkg::row_vec_t                  n;
        qracc_pkg::therm_t [`QRACC_COLS-1:0]  th;   // Codes the model returns
    } mac_vec_t;

    logic clk = 1'b0;
    logic nrst;
    logic mac_en_i, binary_cfg_i;
    qracc_pkg::row_vec_t data_p_i, data_n_i;
    qracc_pkg::row_vec_t psm_vdr_sel_o, psm_vdr_selb_o, psm_vss_sel_o, psm_vss_selb_o;
    qracc_pkg::row_vec_t psm_vrst_sel_o, psm_vrst_selb_o, nsm_vdr_sel_o, nsm_vdr_selb_o;
    qracc_pkg::row_vec_t nsm_vss_sel_o, nsm_vss_selb_o, nsm_vrst_sel_o, nsm_vrst_selb_o;
    logic nf_o, nfb_o, r2a_o, r2ab_o, m2a_o, m2ab_o;
    qracc_pkg::therm_t    [`QRACC_COLS-1:0] therm_i;
    qracc_pkg::adc_code_t [`QRACC_COLS-1:0] adc_out_o;
    logic adc_valid_o;
    logic sram_valid_i, sram_wr_i, sram_ready_o, sram_rvalid_o;
    qracc_pkg::addr_t sram_addr_i;
    qracc_pkg::col_word_t sram_wdata_i, sram_rdata_o, wr_data_o;
    qracc_pkg::col_word_t sa_out_i = '0;
    qracc_pkg::row_vec_t wl_o;
    logic w2b_o, pch_o, saen_o, csel_o;

    mac_vec_t             tbl [N_VEC];
    qracc_pkg::col_word_t mem [16];       // Bitcell array model
    qracc_pkg::col_word_t exp_mem [16];   // Words the testbench wrote
    qracc_pkg::addr_t     wr_addr [N_WR];
    logic [31:0]          rng;
    logic                 exp_valid;
    int                   n_checks;
    int                   n_errors;

    qracc_wrapper i_qracc_wrapper (.*);

    always #2 clk = ~clk;

    task automatic check_rows(input string nm, input qracc_pkg::row_vec_t exp, act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s expected %h actual %h at %0t", nm, exp, act, $time);
        end
    endtask

    task automatic check_code(input string nm, input qracc_pkg::adc_code_t exp, act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s expected %h actual %h at %0t", nm, exp, act, $time);
        end
    endtask

    task automatic check_word(input string nm, input qracc_pkg::col_word_t exp, act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s expected %h actual %h at %0t", nm, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string nm, input logic exp, act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s expected %h actual %h at %0t", nm, exp, act, $time);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Top comparator that fired (counted from 1) less mid scale
    function automatic qracc_pkg::adc_code_t expect_code(input qracc_pkg::therm_t th);
        int pos;
        pos = 0;
        for (int i = `QRACC_COMPS; i >= 1; i--) begin
            if (pos == 0 && th[i-1]) pos = i;
        end
        return qracc_pkg::adc_code_t'(pos - 8);
    endfunction

    function automatic qracc_pkg::addr_t wl_row(input qracc_pkg::row_vec_t wl);
        qracc_pkg::addr_t row;
        row = '0;
        for (int i = 0; i < `QRACC_ROWS; i++) begin
            if (wl[i]) row = qracc_pkg::addr_t'(i);
        end
        return row;
    endfunction

    // Expected switch state for one captured request in one clock phase
    task automatic check_switch(input mac_vec_t v, input logic high_phase);
        qracc_pkg::row_vec_t exp_sel [6];
        qracc_pkg::row_vec_t act_sel [6];
        qracc_pkg::row_vec_t act_selb [6];
        string               nm [6];
        logic                pre;
        nm = '{"psm_vdr", "psm_vss", "psm_vrst", "nsm_vdr", "nsm_vss", "nsm_vrst"};
        act_sel  = '{psm_vdr_sel_o, psm_vss_sel_o, psm_vrst_sel_o,
                     nsm_vdr_sel_o, nsm_vss_sel_o, nsm_vrst_sel_o};
        act_selb = '{psm_vdr_selb_o, psm_vss_selb_o, psm_vrst_selb_o,
                     nsm_vdr_selb_o, nsm_vss_selb_o, nsm_vrst_selb_o};
        pre = high_phase && v.en;
        for (int r = 0; r < `QRACC_ROWS; r++) begin
            exp_sel[0][r] = !pre && v.p[r] && !v.n[r];   // Positive only
            exp_sel[1][r] = !pre && v.n[r] && !v.p[r];   // Negative only
            exp_sel[2][r] = pre || (v.p[r] == v.n[r]);
        end
        if (pre || v.bin) begin
            exp_sel[3] = '0;
            exp_sel[4] = '0;
            exp_sel[5] = '1;
        end else begin
            exp_sel[3] = exp_sel[1];   // NSM swaps the rails
            exp_sel[4] = exp_sel[0];
            exp_sel[5] = exp_sel[2];
        end
        for (int s = 0; s < 6; s++) begin
            check_rows({nm[s], "_sel_o"}, exp_sel[s], act_sel[s]);
            check_rows({nm[s], "_selb_o"}, ~exp_sel[s], act_selb[s]);
        end
        check_bit("nf_o", pre, nf_o);
        check_bit("nfb_o", !pre, nfb_o);
        check_bit("r2a_o", pre, r2a_o);
        check_bit("r2ab_o", !pre, r2ab_o);
        check_bit("m2a_o", !pre, m2a_o);
        check_bit("m2ab_o", pre, m2ab_o);
    endtask

    task automatic build_table();
        tbl[0] = '{1'b1, 1'b0, 16'h00ff, 16'h0f0f, {15'h7fff, 15'h0, 15'h00ff, 15'h1}};
        tbl[1] = '{1'b1, 1'b0, 16'hffff, 16'h0000, {15'h0, 15'h7fff, 15'h003f, 15'h1fff}};
        tbl[2] = '{1'b1, 1'b1, 16'ha5a5, 16'h5a5a, {15'h7, 15'h07ff, 15'h0, 15'h7fff}};
        tbl[3] = '{1'b0, 1'b1, 16'h1234, 16'h4321, {15'h00ff, 15'h3, 15'h1, 15'h0}};
        tbl[4] = '{1'b1, 1'b1, 16'h0000, 16'hffff, {15'h1, 15'h0fff, 15'h7fff, 15'h7f}};
        tbl[5] = '{1'b0, 1'b0, 16'hf00f, 16'h0ff0, {15'h0, 15'h0, 15'h0, 15'h0}};
        tbl[6] = '{1'b1, 1'b0, 16'hffff, 16'hffff, {4{15'h7fff}}};
        tbl[7] = '{1'b1, 1'b0, 16'h0000, 16'h0000, {4{15'h0}}};
        for (int i = N_FIX; i < N_VEC; i++) begin
            rng = xorshift32(rng);
            tbl[i].p = rng[15:0];
            tbl[i].n = rng[31:16];
            rng = xorshift32(rng);
            tbl[i].en  = rng[0] | rng[1];   // Mostly enabled
            tbl[i].bin = rng[2];
            for (int c = 0; c < `QRACC_COLS; c++) begin
                tbl[i].th[c] = 15'h7fff >> rng[4*c+4 +: 4];
            end
        end
    endtask

    // Array model with bitcell writes and sense amp latch on the falling edge
    always @(negedge clk) begin
        if (!nrst) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= qracc_pkg::col_word_t'(i) ^ 4'h9;
            end
            sa_out_i <= '0;
        end else begin
            if (w2b_o) mem[wl_row(wl_o)] <= wr_data_o;
            if (saen_o) sa_out_i <= mem[wl_row(wl_o)];
        end
    end

    // Raises a request and returns just after the accepting edge
    task automatic sram_request(input logic wr, input qracc_pkg::addr_t a,
                                input qracc_pkg::col_word_t d);
        int waited;
        sram_valid_i = 1'b1;
        sram_wr_i    = wr;
        sram_addr_i  = a;
        sram_wdata_i = d;
        waited = 0;
        while (!sram_ready_o && waited < 16) begin
            @(posedge clk);
            #0.5;
            waited++;
        end
        if (!sram_ready_o) begin
            n_errors++;
            $display("SRAM request to address %h never saw ready", a);
        end
        @(posedge clk);
        #0.5;
    endtask

    task automatic write_sequence(input qracc_pkg::addr_t a, input qracc_pkg::col_word_t d);
        qracc_pkg::row_vec_t exp_wl;
        exp_wl    = '0;
        exp_wl[a] = 1'b1;
        check_bit("sram_ready_o", 1'b0, sram_ready_o);
        check_bit("pch_o", 1'b0, pch_o);   // Precharge phase
        check_bit("csel_o", 1'b1, csel_o);
        @(posedge clk);
        #0.5;
        check_rows("wl_o", exp_wl, wl_o);
        check_word("wr_data_o", d, wr_data_o);
        check_bit("w2b_o", 1'b1, w2b_o);
        check_bit("csel_o", 1'b1, csel_o);
        check_bit("sram_ready_o", 1'b0, sram_ready_o);
        @(posedge clk);
        #0.5;
        check_bit("sram_ready_o", 1'b0, sram_ready_o);
        check_bit("csel_o", 1'b1, csel_o);
        @(posedge clk);
        #0.5;
        check_bit("sram_ready_o", 1'b1, sram_ready_o);   // Idle 3 cycles after acceptance
        check_bit("csel_o", 1'b0, csel_o);
        exp_mem[a] = d;
    endtask

    task automatic read_sequence(input qracc_pkg::addr_t a);
        int lat;
        lat = 0;
        while (!sram_rvalid_o && lat < 12) begin
            @(posedge clk);
            #0.5;
            lat++;
        end
        if (!sram_rvalid_o) begin
            n_errors++;
            $display("Read of address %h never returned data", a);
        end else if (lat != 4) begin
            n_errors++;
            $display("Read of address %h returned after %0d cycles, 4 expected", a, lat);
        end
        check_word("sram_rdata_o", exp_mem[a], sram_rdata_o);
        @(posedge clk);
        #0.5;
        check_bit("sram_rvalid_o", 1'b0, sram_rvalid_o);   // Single cycle pulse
    endtask

    initial begin
        #((N_VEC + N_OPS) * 8 * 4 + 200);
        $display("Watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rng          = 32'd7472;
        n_checks     = 0;
        n_errors     = 0;
        nrst         = 1'b0;
        mac_en_i     = 1'b0;
        binary_cfg_i = 1'b0;
        data_p_i     = '0;
        data_n_i     = '0;
        therm_i      = '0;
        sram_valid_i = 1'b0;
        sram_wr_i    = 1'b0;
        sram_addr_i  = '0;
        sram_wdata_i = '0;
        build_table();
        repeat (3) @(posedge clk);
        #0.5;
        nrst = 1'b1;

        check_bit("sram_ready_o", 1'b1, sram_ready_o);
        check_bit("sram_rvalid_o", 1'b0, sram_rvalid_o);
        check_bit("adc_valid_o", 1'b0, adc_valid_o);
        check_bit("pch_o", 1'b1, pch_o);
        check_bit("saen_o", 1'b0, saen_o);
        check_bit("w2b_o", 1'b0, w2b_o);
        check_bit("csel_o", 1'b0, csel_o);
        check_bit("m2a_o", 1'b1, m2a_o);   // Captured enable clear in the high phase
        check_rows("wl_o", '0, wl_o);
        for (int c = 0; c < `QRACC_COLS; c++) begin
            check_code($sformatf("adc_out_o[%0d]", c), '0, adc_out_o[c]);
        end

        // One request per cycle with two in flight
        for (int cyc = 0; cyc < N_VEC + 2; cyc++) begin
            @(posedge clk);
            #0.5;
            mac_en_i = 1'b0;
            if (cyc < N_VEC) begin
                mac_en_i     = tbl[cyc].en;
                binary_cfg_i = tbl[cyc].bin;
                data_p_i     = tbl[cyc].p;
                data_n_i     = tbl[cyc].n;
            end
            if (cyc >= 1 && cyc <= N_VEC) therm_i = tbl[cyc-1].th;   // Analog phase
            exp_valid = 1'b0;
            if (cyc >= 2) exp_valid = tbl[cyc-2].en;
            check_bit("adc_valid_o", exp_valid, adc_valid_o);
            if (exp_valid) begin
                for (int c = 0; c < `QRACC_COLS; c++) begin
                    check_code($sformatf("adc_out_o[%0d]", c),
                               expect_code(tbl[cyc-2].th[c]), adc_out_o[c]);
                end
            end
            if (cyc >= 1 && cyc <= N_VEC) begin
                #0.5;
                check_switch(tbl[cyc-1], 1'b1);
                #2;
                check_switch(tbl[cyc-1], 1'b0);
            end
        end

        for (int i = 0; i < N_WR; i++) begin
            rng = xorshift32(rng);
            wr_addr[i] = rng[3:0];
            sram_request(1'b1, rng[3:0], rng[11:8]);
            sram_valid_i = 1'b0;
            write_sequence(wr_addr[i], rng[11:8]);
        end
        for (int i = 0; i < N_WR; i++) begin
            sram_request(1'b0, wr_addr[i], '0);
            sram_valid_i = 1'b0;
            read_sequence(wr_addr[i]);
        end

        // Read held high while the write before it is busy
        rng = xorshift32(rng);
        sram_request(1'b1, rng[7:4], rng[15:12]);
        sram_wr_i = 1'b0;
        write_sequence(rng[7:4], rng[15:12]);
        sram_request(1'b0, rng[7:4], '0);
        sram_valid_i = 1'b0;
        read_sequence(rng[7:4]);

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/qracc_pkg.sv
design/qracc_mac_if.sv
design/qracc_input_stage.sv
design/qracc_switch_driver.sv
design/qracc_adc_encoder.sv
design/qracc_sram_ctrl.sv
design/qracc_wrapper.sv
bench/qracc_tb.sv

/* run.sh */
#!/bin/sh
# Builds the wrapper testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module qracc_tb -o qracc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/qracc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation binary returned status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0
